// File: common/UfiPkg.sv
/*
 * Shared types of the RAM access subsystem
 *  - vector typedefs for bus, RAM data and address widths
 *  - RAM command encoding
 *  - sequencer state enum
 */
`default_nettype none

`include "Ufi_cfg.svh"

package UfiPkg;

	// ----------------------------------------
	// Vector types
	// ----------------------------------------
	// Bus word, data and address alike
	typedef logic [`UFI_USI_BUS_WIDTH-1:0] usiWord_t;
	// RAM data word
	typedef logic [`UFI_DQ_WIDTH-1:0] ramDq_t;
	// Full RAM address register
	typedef logic [`UFI_ADRS_WIDTH-1:0] ramAdrs_t;
	// Array address, wraps at 1024 words
	typedef logic [`UFI_SRAM_ADRS_WIDTH-1:0] sramAdrs_t;
	// Bit 0 go, bit 1 read (0 means write)
	typedef logic [1:0] ramCmd_t;

	// ----------------------------------------
	// Sequencer FSM
	// ----------------------------------------
	typedef enum logic [1:0]
	{
		IDLE,
		WAIT,
		ACCESS,
		DONE
	} ramSeqState_t;

endpackage

`default_nettype wire

// File: common/Ufi_cfg.svh
/*
 * Configuration macros of the RAM access subsystem
 *  - bus, RAM data and address widths
 *  - CSR block map, write qualifier bit and register offsets
 *  - sequencer wait count
 */
`ifndef UFI_CFG_SVH
`define UFI_CFG_SVH

// Widths
`define UFI_USI_BUS_WIDTH    32
`define UFI_DQ_WIDTH         16
`define UFI_ADRS_WIDTH       32
`define UFI_SRAM_ADRS_WIDTH  10

// Block map on bus address bits 23..16
`define UFI_CSR_BLOCK_ADRS   8'h06
// Bus address bit that marks a write
`define UFI_CSR_WRITE_BIT    30
// Offset bits seen by the read mux
`define UFI_CSR_ACTIVE_WIDTH 8
// Wait cycles before the RAM is touched
`define UFI_ACCESS_WAIT      4

// Register offsets
`define UFI_REG_RAMWD        8'h00
`define UFI_REG_RAMADRS      8'h04
`define UFI_REG_RAMCMD       8'h08
`define UFI_REG_RAMRDY       8'h40
`define UFI_REG_RAMRD        8'h44

`endif

// File: mcuCsr/MicroControllerCsr.sv
/*
 * Control and status registers for the RAM sequencer
 *  - write decode on bit 30, block map and offset
 *  - RAMWD, RAMADRS, RAMCMD registers and go strobe
 *  - registered bus read with echo of unmapped offsets
 */
`timescale 1ns/10ps
`default_nettype none

`include "Ufi_cfg.svh"

module MicroControllerCsr
(
	// Bus master
	input  wire UfiPkg::usiWord_t iSUsiWd,
	input  wire UfiPkg::usiWord_t iSUsiAdrs,
	output UfiPkg::usiWord_t      oSUsiRd,
	// Toward the sequencer
	output UfiPkg::ramDq_t        oRamWd,
	output UfiPkg::ramAdrs_t      oRamAdrs,
	output logic                  oRamRw,
	output logic                  oRamEn,
	// From the sequencer
	input  wire                   iRamRdy,
	input  wire UfiPkg::ramDq_t   iRamRd,
	// Clock and reset
	input  wire                   iSRST,
	input  wire                   iSCLK
);

	// ----------------------------------------
	// Write decode
	// ----------------------------------------
	logic [`UFI_CSR_ACTIVE_WIDTH-1:0] qCsrOfs;
	logic qBlockWr;
	logic qWrRamWd;
	logic qWrRamAdrs;
	logic qWrRamCmd;
	UfiPkg::ramCmd_t rRamCmd;
	logic rRamRdy;

	assign qCsrOfs = iSUsiAdrs[`UFI_CSR_ACTIVE_WIDTH-1:0];

	// Write bit, block map, upper offset bits all zero
	assign qBlockWr = iSUsiAdrs[`UFI_CSR_WRITE_BIT]
		& (iSUsiAdrs[23:16] == `UFI_CSR_BLOCK_ADRS)
		& (iSUsiAdrs[15:`UFI_CSR_ACTIVE_WIDTH] == '0);

	assign qWrRamWd   = qBlockWr & (qCsrOfs == `UFI_REG_RAMWD);
	assign qWrRamAdrs = qBlockWr & (qCsrOfs == `UFI_REG_RAMADRS);
	assign qWrRamCmd  = qBlockWr & (qCsrOfs == `UFI_REG_RAMCMD);

	// Direction straight from the stored command
	assign oRamRw = rRamCmd[1];

	// ----------------------------------------
	// Register map
	// ----------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			oRamWd   <= '0;
			oRamAdrs <= '0;
			rRamCmd  <= '0;
			oRamEn   <= 1'b0;
			rRamRdy  <= 1'b0;
		end
		else
		begin
			// RAMWD keeps the low data bits only
			if (qWrRamWd)
			begin
				oRamWd <= iSUsiWd[`UFI_DQ_WIDTH-1:0];
			end
			if (qWrRamAdrs)
			begin
				oRamAdrs <= iSUsiWd;
			end
			if (qWrRamCmd)
			begin
				rRamCmd <= iSUsiWd[1:0];
			end
			// Go strobe one cycle after a go write
			oRamEn <= qWrRamCmd & iSUsiWd[0];
			// Ready passes one sync stage
			rRamRdy <= iRamRdy;
		end
	end

	// ----------------------------------------
	// Bus read
	// ----------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			oSUsiRd <= '0;
		end
		else
		begin
			// Narrow registers zero-filled to bus width
			case (qCsrOfs)
				`UFI_REG_RAMWD:
					oSUsiRd <= {{(`UFI_USI_BUS_WIDTH - `UFI_DQ_WIDTH){1'b0}}, oRamWd};
				`UFI_REG_RAMADRS:
					oSUsiRd <= oRamAdrs;
				`UFI_REG_RAMCMD:
					oSUsiRd <= {{(`UFI_USI_BUS_WIDTH - 2){1'b0}}, rRamCmd};
				`UFI_REG_RAMRDY:
					oSUsiRd <= {{(`UFI_USI_BUS_WIDTH - 1){1'b0}}, rRamRdy};
				`UFI_REG_RAMRD:
					oSUsiRd <= {{(`UFI_USI_BUS_WIDTH - `UFI_DQ_WIDTH){1'b0}}, iRamRd};
				// Unmapped offset echoes the write bus
				default:
					oSUsiRd <= iSUsiWd;
			endcase
		end
	end

	// Go strobe lasts exactly one cycle
	assert property (@(posedge iSCLK) disable iff (iSRST) oRamEn |=> !oRamEn);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the RAM subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tbMicroControllerRamSys \
	-f verilog.f \
	-o simRamSys

# The log decides the result
./obj_dir/simRamSys > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qx "Testbench passed" "$LOG"
then
	echo "Simulation result: PASS"
else
	echo "Simulation result: FAIL"
	exit 1
fi

// File: testbench/ramsys_stimulus.txt
# T n starts test n, W adrs data is a bus write, P polls RAMRDY until it returns to 1
# R adrs data expected reads adrs with data on the write bus and checks expected (hex)
T 1
R 00060000 00000000 00000000
R 00060004 00000000 00000000
R 00060008 00000000 00000000
R 00060040 00000000 00000001
T 2
W 40060000 a5a5c3d2
R 00060000 00000000 0000c3d2
W 40060004 8badf00d
R 00060004 00000000 8badf00d
T 3
W 00060000 0000ffff
W 40070004 11112222
W 40060100 00007777
R 00060000 00000000 0000c3d2
R 00060004 00000000 8badf00d
R 00060010 12345678 12345678
T 4
W 40060004 00000003
W 40060000 00001234
W 40060008 00000001
P
W 40060004 00000400
W 40060000 0000beef
W 40060008 00000001
P
W 40060004 00000003
W 40060008 00000003
P
R 00060044 00000000 00001234
W 40060004 00000000
W 40060008 00000003
P
R 00060044 00000000 0000beef
T 5
W 40060004 00000005
W 40060000 0000aaaa
W 40060008 00000001
W 40060000 0000bbbb
W 40060008 00000001
P
W 40060008 00000003
P
R 00060044 00000000 0000aaaa

// File: testbench/tbClockGen.sv
/*
 * Testbench clock and reset source
 *  - 4 ns clock
 *  - synchronous reset held for two cycles
 */
`timescale 1ns/10ps
`default_nettype none

module tbClockGen
#(
	parameter int pHalfPeriod  = 2,
	parameter int pResetCycles = 2
)
(
	output logic iSCLK,
	output logic iSRST
);

	// Free running clock
	initial
	begin
		iSCLK = 1'b0;
		forever
		begin
			#pHalfPeriod iSCLK = ~iSCLK;
		end
	end

	// Reset seen by two rising edges, released on a falling edge
	initial
	begin
		iSRST = 1'b1;
		repeat (pResetCycles) @(posedge iSCLK);
		@(negedge iSCLK);
		iSRST = 1'b0;
	end

endmodule

`default_nettype wire

// File: testbench/tbMicroControllerRamSys.sv
/*
 * Testbench for the RAM access subsystem
 *  - loads the operation list from the stimulus file
 *  - bus write, checked read and RAMRDY poll tasks
 *  - per-test result lines, closing counts and watchdog
 */
`timescale 1ns/10ps
`default_nettype none

`include "Ufi_cfg.svh"

module tbMicroControllerRamSys;

	localparam int lpPollLimit     = 50;
	localparam int lpCyclesPerLine = 60;
	// Plain read of RAMRDY, write bit clear
	localparam UfiPkg::usiWord_t lpRdyAdrs =
		{8'h00, `UFI_CSR_BLOCK_ADRS, 8'h00, `UFI_REG_RAMRDY};

	wire iSCLK;
	wire iSRST;
	UfiPkg::usiWord_t busWd;
	UfiPkg::usiWord_t busAdrs;
	wire UfiPkg::usiWord_t busRd;

	// Stimulus lines and bookkeeping
	string stimLines[$];
	int lineCount;
	int testNum;
	int testChecks;
	int testErrors;
	int passCount;
	int failCount;

	tbClockGen tbClockGen_inst
	(
		.iSCLK (iSCLK),
		.iSRST (iSRST)
	);

	MicroControllerRamSys MicroControllerRamSys_inst
	(
		.iSUsiWd   (busWd),
		.iSUsiAdrs (busAdrs),
		.oSUsiRd   (busRd),
		.iSRST     (iSRST),
		.iSCLK     (iSCLK)
	);

	// ----------------------------------------
	// Bus tasks, entered on a falling edge
	// ----------------------------------------
	// One write cycle, then back to an idle read of offset 0
	task automatic busWrite(input UfiPkg::usiWord_t adrs, input UfiPkg::usiWord_t data);
		busAdrs = adrs;
		busWd   = data;
		@(negedge iSCLK);
		busAdrs = '0;
		busWd   = '0;
	endtask

	// Read data valid one edge after the address
	task automatic busReadCheck(input UfiPkg::usiWord_t adrs, input UfiPkg::usiWord_t data,
		input UfiPkg::usiWord_t expected);
		busAdrs = adrs;
		busWd   = data;
		@(negedge iSCLK);
		testChecks++;
		if (busRd !== expected)
		begin
			$display("Fail at %0t ns: read of %h returned %h, expected %h",
				$time, adrs, busRd, expected);
			testErrors++;
		end
		busAdrs = '0;
		busWd   = '0;
	endtask

	// Ready must drop for the command, then come back
	task automatic pollReady;
		int cycles;
		logic sawBusy;
		logic done;
		cycles  = 0;
		sawBusy = 1'b0;
		done    = 1'b0;
		busAdrs = lpRdyAdrs;
		busWd   = '0;
		while (!done && cycles < lpPollLimit)
		begin
			@(negedge iSCLK);
			cycles++;
			if (busRd[0] == 1'b0)
			begin
				sawBusy = 1'b1;
			end
			else if (sawBusy)
			begin
				done = 1'b1;
			end
		end
		testChecks++;
		if (!done)
		begin
			if (sawBusy)
			begin
				$display("RAMRDY did not return to 1 within %0d cycles, at %0t ns",
					lpPollLimit, $time);
			end
			else
			begin
				$display("RAMRDY never went low for the command, gave up at %0t ns", $time);
			end
			testErrors++;
		end
		busAdrs = '0;
	endtask

	// Result line of the test that just ended
	task automatic finishTest;
		if (testNum > 0)
		begin
			if (testErrors == 0)
			begin
				$display("Test %0d ok, %0d checks", testNum, testChecks);
				passCount++;
			end
			else
			begin
				$display("Test %0d FAILED, %0d of %0d checks wrong", testNum, testErrors,
					testChecks);
				failCount++;
			end
		end
		testChecks = 0;
		testErrors = 0;
	endtask

	// Whole file into the line queue
	task automatic loadStimulus(output logic ok);
		int fd;
		int rc;
		string line;
		fd = $fopen("testbench/ramsys_stimulus.txt", "r");
		ok = (fd != 0);
		if (ok)
		begin
			while (!$feof(fd))
			begin
				rc = $fgets(line, fd);
				if (rc > 0)
				begin
					stimLines.push_back(line);
				end
			end
			$fclose(fd);
		end
	endtask

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------
	initial
	begin
		logic loaded;
		int rc;
		byte op;
		UfiPkg::usiWord_t adrs;
		UfiPkg::usiWord_t data;
		UfiPkg::usiWord_t expected;
		busAdrs    = '0;
		busWd      = '0;
		lineCount  = 0;
		testNum    = 0;
		testChecks = 0;
		testErrors = 0;
		passCount  = 0;
		failCount  = 0;
		loadStimulus(loaded);
		if (!loaded)
		begin
			$display("Could not open testbench/ramsys_stimulus.txt");
			$display("Testbench failed");
			$finish;
		end
		else
		begin
			lineCount = stimLines.size();
			wait (iSRST == 1'b0);
			@(negedge iSCLK);
			foreach (stimLines[i])
			begin
				op = stimLines[i].getc(0);
				case (op)
					"T":
					begin
						finishTest();
						rc = $sscanf(stimLines[i], "T %d", testNum);
					end
					"W":
					begin
						rc = $sscanf(stimLines[i], "W %h %h", adrs, data);
						busWrite(adrs, data);
					end
					"R":
					begin
						rc = $sscanf(stimLines[i], "R %h %h %h", adrs, data, expected);
						busReadCheck(adrs, data, expected);
					end
					"P":
					begin
						pollReady();
					end
					// Comments and blank lines
					default:
					begin
					end
				endcase
			end
			finishTest();
			$display("Tests passed %0d, tests failed %0d", passCount, failCount);
			if (failCount == 0)
			begin
				$display("Testbench passed");
			end
			else
			begin
				$display("Testbench failed");
			end
			$finish;
		end
	end

	// ----------------------------------------
	// Watchdog
	// ----------------------------------------
	initial
	begin
		wait (lineCount > 0);
		repeat (lineCount * lpCyclesPerLine) @(posedge iSCLK);
		$display("Watchdog expired after %0d cycles, the run did not finish",
			lineCount * lpCyclesPerLine);
		$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: ufiRam/UfiRamCtrl.sv
/*
 * One-word RAM access sequencer
 *  - accepts a go strobe while idle, drops it while busy
 *  - wait cycles, access cycle, read capture cycle
 *  - ready level and held read word
 */
`timescale 1ns/10ps
`default_nettype none

`include "Ufi_cfg.svh"

module UfiRamCtrl
(
	// Command side, from the CSR block
	input  wire UfiPkg::ramDq_t   iRamWd,
	input  wire UfiPkg::ramAdrs_t iRamAdrs,
	input  wire                   iRamRw,
	input  wire                   iRamEn,
	output logic                  oRamRdy,
	output UfiPkg::ramDq_t        oRamRd,
	// RAM side
	output logic                  oSramWe,
	output UfiPkg::sramAdrs_t     oSramAdrs,
	output UfiPkg::ramDq_t        oSramWd,
	input  wire UfiPkg::ramDq_t   iSramRd,
	// Clock and reset
	input  wire                   iSRST,
	input  wire                   iSCLK
);

	// ----------------------------------------
	// Wait counter sizing
	// ----------------------------------------
	localparam int lpWaitCntWidth = $clog2(`UFI_ACCESS_WAIT + 1);
	localparam logic [lpWaitCntWidth-1:0] lpWaitLast = lpWaitCntWidth'(`UFI_ACCESS_WAIT - 1);

	UfiPkg::ramSeqState_t rState;
	logic [lpWaitCntWidth-1:0] rWaitCnt;
	logic rRw;
	UfiPkg::sramAdrs_t rAdrs;
	UfiPkg::ramDq_t rWd;
	logic qAccept;

	// Strobe only counts while idle
	assign qAccept = (rState == UfiPkg::IDLE) & iRamEn;

	// ----------------------------------------
	// Sequencer FSM
	// ----------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			rState   <= UfiPkg::IDLE;
			rWaitCnt <= '0;
			rRw      <= 1'b0;
			oRamRd   <= '0;
		end
		else
		begin
			case (rState)
				UfiPkg::IDLE:
				begin
					rWaitCnt <= '0;
					if (qAccept)
					begin
						rRw    <= iRamRw;
						rState <= UfiPkg::WAIT;
					end
				end
				// Access wait, UFI_ACCESS_WAIT cycles
				UfiPkg::WAIT:
				begin
					if (rWaitCnt == lpWaitLast)
					begin
						rState <= UfiPkg::ACCESS;
					end
					else
					begin
						rWaitCnt <= rWaitCnt + 1'b1;
					end
				end
				// Write enable or read address this cycle
				UfiPkg::ACCESS:
				begin
					rState <= UfiPkg::DONE;
				end
				// Registered RAM read valid here
				UfiPkg::DONE:
				begin
					if (rRw)
					begin
						oRamRd <= iSramRd;
					end
					rState <= UfiPkg::IDLE;
				end
				default:
				begin
					rState <= UfiPkg::IDLE;
				end
			endcase
		end
	end

	// Address and data latched on accept
	always_ff @(posedge iSCLK)
	begin
		if (qAccept)
		begin
			rAdrs <= iRamAdrs[`UFI_SRAM_ADRS_WIDTH-1:0];
			rWd   <= iRamWd;
		end
	end

	// ----------------------------------------
	// Outputs
	// ----------------------------------------
	assign oRamRdy   = (rState == UfiPkg::IDLE);
	assign oSramWe   = (rState == UfiPkg::ACCESS) & ~rRw;
	assign oSramAdrs = rAdrs;
	assign oSramWd   = rWd;

	// Write only after a full wait with ready low
	assert property (@(posedge iSCLK) disable iff (iSRST)
		oSramWe |-> !oRamRdy && $past(!oRamRdy, `UFI_ACCESS_WAIT));

endmodule

`default_nettype wire

// File: ufiRam/UfiSram.sv
/*
 * Single-port synchronous RAM
 *  - 1024 by 16 words
 *  - synchronous write, registered read
 */
`timescale 1ns/10ps
`default_nettype none

`include "Ufi_cfg.svh"

module UfiSram
(
	// Write enable, one word per cycle
	input  wire                    iWe,
	input  wire UfiPkg::sramAdrs_t iAdrs,
	input  wire UfiPkg::ramDq_t    iWd,
	output UfiPkg::ramDq_t         oRd,
	input  wire                    iSCLK
);

	// ----------------------------------------
	// Storage
	// ----------------------------------------
	localparam int lpDepth = 1 << `UFI_SRAM_ADRS_WIDTH;

	UfiPkg::ramDq_t rMem [0:lpDepth-1];

	// Write port
	always_ff @(posedge iSCLK)
	begin
		if (iWe)
		begin
			rMem[iAdrs] <= iWd;
		end
	end

	// Read port, data one cycle after the address
	// old contents on a same-cycle write
	always_ff @(posedge iSCLK)
	begin
		oRd <= rMem[iAdrs];
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+common
common/UfiPkg.sv
mcuCsr/MicroControllerCsr.sv
ufiRam/UfiRamCtrl.sv
ufiRam/UfiSram.sv
verilog/MicroControllerRamSys.sv
testbench/tbClockGen.sv
testbench/tbMicroControllerRamSys.sv

// File: verilog/MicroControllerRamSys.sv
/*
 * RAM access subsystem top level
 *  - CSR block on the bus
 *  - access sequencer and local RAM
 */
`timescale 1ns/10ps
`default_nettype none

module MicroControllerRamSys
(
	// Bus master
	input  wire UfiPkg::usiWord_t iSUsiWd,
	input  wire UfiPkg::usiWord_t iSUsiAdrs,
	output wire UfiPkg::usiWord_t oSUsiRd,
	// Clock and reset
	input  wire                   iSRST,
	input  wire                   iSCLK
);

	// ----------------------------------------
	// CSR to sequencer
	// ----------------------------------------
	wire UfiPkg::ramDq_t   wRamWd;
	wire UfiPkg::ramAdrs_t wRamAdrs;
	wire                   wRamRw;
	wire                   wRamEn;
	wire                   wRamRdy;
	wire UfiPkg::ramDq_t   wRamRd;

	// Sequencer to RAM
	wire                    wSramWe;
	wire UfiPkg::sramAdrs_t wSramAdrs;
	wire UfiPkg::ramDq_t    wSramWd;
	wire UfiPkg::ramDq_t    wSramRd;

	MicroControllerCsr MicroControllerCsr_inst
	(
		.iSUsiWd   (iSUsiWd),
		.iSUsiAdrs (iSUsiAdrs),
		.oSUsiRd   (oSUsiRd),
		.oRamWd    (wRamWd),
		.oRamAdrs  (wRamAdrs),
		.oRamRw    (wRamRw),
		.oRamEn    (wRamEn),
		.iRamRdy   (wRamRdy),
		.iRamRd    (wRamRd),
		.iSRST     (iSRST),
		.iSCLK     (iSCLK)
	);

	UfiRamCtrl UfiRamCtrl_inst
	(
		.iRamWd    (wRamWd),
		.iRamAdrs  (wRamAdrs),
		.iRamRw    (wRamRw),
		.iRamEn    (wRamEn),
		.oRamRdy   (wRamRdy),
		.oRamRd    (wRamRd),
		.oSramWe   (wSramWe),
		.oSramAdrs (wSramAdrs),
		.oSramWd   (wSramWd),
		.iSramRd   (wSramRd),
		.iSRST     (iSRST),
		.iSCLK     (iSCLK)
	);

	UfiSram UfiSram_inst
	(
		.iWe   (wSramWe),
		.iAdrs (wSramAdrs),
		.iWd   (wSramWd),
		.oRd   (wSramRd),
		.iSCLK (iSCLK)
	);

endmodule

`default_nettype wire
